// ==== Makefile ====
TOP = tb_board_input

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== board_ctrl.sv ====
////////////////////////////////////////
// Board control
// Power-on hold, reset merge, reboot request,
// status LED and core input packing
////////////////////////////////////////
`timescale 1ns/1ns

module board_ctrl
  import board_pkg::*;
#(
  parameter int HOLD_CYCLES = 256
) (
  input  logic      ena_x,
  input  logic      pll_lckd,
  input  joy_word_t joy1,
  input  joy_word_t joy2,
  input  key_ctrl_t keys,
  input  logic      btn,
  input  logic      scandbl,
  output core_in_t  core_in,
  output logic      core_reset,
  output logic      reboot_req,
  output logic      led
);

  localparam int CNT_W = $clog2(HOLD_CYCLES + 1);
  localparam logic [CNT_W-1:0] HOLD_END = CNT_W'(HOLD_CYCLES);

  logic [CNT_W-1:0] hold_cnt;
  logic [CNT_W-1:0] hold_cnt_nxt;
  logic             hold_on;
  logic             reset_src;
  logic             reboot_cond;
  logic             reboot_cond_q;
  core_in_t         core_in_nxt;

  // Saturates at the end of the hold
  assign hold_cnt_nxt = (hold_cnt == HOLD_END) ? hold_cnt : hold_cnt + CNT_W'(1);
  assign hold_on      = (hold_cnt_nxt != HOLD_END);

  // Reset key or stick 1 reset button
  assign reset_src   = keys.reset_key | ~joy1[11];
  // Ctrl+backspace or stick 2 reset button
  assign reboot_cond = keys.master_reset | ~joy2[11];

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      hold_cnt      <= '0;
      core_reset    <= 1'b1;
      reboot_cond_q <= 1'b0;
      reboot_req    <= 1'b0;
    end else begin
      hold_cnt      <= hold_cnt_nxt;
      core_reset    <= hold_on | reset_src;
      reboot_cond_q <= reboot_cond;
      // Rising edge only, one pulse per press
      reboot_req    <= reboot_cond & ~reboot_cond_q;
    end
  end

  ////////////////////////////////////////
  // Core inputs and LED
  ////////////////////////////////////////

  always_comb begin
    core_in_nxt.stick_a  = joy1[5:0];
    core_in_nxt.stick_b  = joy2[5:0];
    core_in_nxt.player_n = {joy2[8], joy1[8]};
    // Front panel button shares coin 1
    core_in_nxt.coin_n   = {joy2[9], joy1[9] & btn};
  end

  always_ff @(posedge ena_x) begin
    core_in <= core_in_nxt;
    led     <= keys.scan_mode ^ scandbl;
  end

endmodule

// ==== board_input_properties.sv ====
////////////////////////////////////////
// Board input properties
// Timing rules of the front end top level
////////////////////////////////////////
`timescale 1ns/1ns

module board_input_properties (
  input logic ena_x,
  input logic pll_lckd,
  input logic joy_load,
  input logic reboot_req,
  input logic code_valid
);

  // High cycles seen since the last load
  int gap;

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      gap <= 25;
    end else if (!joy_load) begin
      gap <= 0;
    end else begin
      gap <= gap + 1;
    end
  end

  // Load low once in 26
  a_load_low: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |-> gap == 25) else $error("joy_load low too early");
  a_load_high: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    joy_load |-> gap < 25) else $error("joy_load high too long");

  a_reboot: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    reboot_req |=> !reboot_req) else $error("reboot_req longer than one cycle");
  a_valid: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    code_valid |=> !code_valid) else $error("code_valid longer than one cycle");

endmodule

bind board_input_top board_input_properties i_props (
  .ena_x      (ena_x),
  .pll_lckd   (pll_lckd),
  .joy_load   (joy_load),
  .reboot_req (reboot_req),
  .code_valid (code_valid)
);

// ==== board_input_top.sv ====
////////////////////////////////////////
// Board input top
// Joystick reader, keyboard path and
// control block side by side
////////////////////////////////////////
`timescale 1ns/1ns

module board_input_top
  import board_pkg::*;
#(
  parameter int HOLD_CYCLES = 256
) (
  input  logic     ena_x,
  input  logic     pll_lckd,
  // Joystick shift register
  output logic     joy_clk,
  output logic     joy_load,
  input  logic     joy_data,
  // Keyboard and front panel
  input  logic     ps2_clk,
  input  logic     ps2_data,
  input  logic     btn,
  input  logic     scandbl,
  // Arcade core side
  output core_in_t core_in,
  output logic     core_reset,
  output logic     reboot_req,
  output logic     led
);

  joy_word_t  joy1;
  joy_word_t  joy2;
  scan_code_t code;
  logic       code_valid;
  key_ctrl_t  keys;

  // Shift register runs on the system clock
  assign joy_clk = ena_x;

  joy_frame_reader i_joy (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .joy_data (joy_data),
    .joy_load (joy_load),
    .joy1     (joy1),
    .joy2     (joy2)
  );

  ps2_receiver i_ps2 (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .code       (code),
    .code_valid (code_valid)
  );

  key_decoder i_keys (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .code       (code),
    .code_valid (code_valid),
    .keys       (keys)
  );

  board_ctrl #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) i_ctrl (
    .ena_x      (ena_x),
    .pll_lckd   (pll_lckd),
    .joy1       (joy1),
    .joy2       (joy2),
    .keys       (keys),
    .btn        (btn),
    .scandbl    (scandbl),
    .core_in    (core_in),
    .core_reset (core_reset),
    .reboot_req (reboot_req),
    .led        (led)
  );

endmodule

// ==== board_pkg.sv ====
////////////////////////////////////////
// Board input package
// Shared types and codes for the joystick,
// keyboard and core control front end
////////////////////////////////////////
package board_pkg;

  ////////////////////////////////////////
  // Joystick serial frame
  ////////////////////////////////////////

  // One stick, active low
  // 0-5 stick and fire, 8 start, 9 coin, 11 reset
  typedef logic [11:0] joy_word_t;

  // Slot position inside a 26 slot frame
  typedef logic [4:0] slot_t;

  // Bit position inside a joystick word
  typedef logic [3:0] joy_bit_t;

  // First and last slot that carry a button bit
  localparam slot_t SLOT_FIRST_BIT = 5'd2;
  localparam slot_t SLOT_LAST      = 5'd25;

  // Nothing pressed
  localparam joy_word_t JOY_IDLE = 12'hfff;

  ////////////////////////////////////////
  // PS/2 keyboard
  ////////////////////////////////////////

  typedef logic [7:0] scan_code_t;

  // Prefixes
  localparam scan_code_t SC_EXT   = 8'he0;
  localparam scan_code_t SC_BREAK = 8'hf0;

  // Control keys, set 2
  localparam scan_code_t SC_LCTRL = 8'h14;
  localparam scan_code_t SC_BKSP  = 8'h66;
  localparam scan_code_t SC_F12   = 8'h07;
  localparam scan_code_t SC_SCRLK = 8'h7e;

  // Decoded keyboard controls
  typedef struct packed {
    logic reset_key;     // F12 held
    logic master_reset;  // left ctrl + backspace held
    logic scan_mode;     // toggled by scroll lock
  } key_ctrl_t;

  // Inputs of the arcade core, active low
  typedef struct packed {
    logic [5:0] stick_a;
    logic [5:0] stick_b;
    logic [1:0] player_n;
    logic [1:0] coin_n;
  } core_in_t;

endpackage

// ==== joy_frame_reader.sv ====
////////////////////////////////////////
// Joystick frame reader
// Scans two 12-button sticks through an
// external parallel-in shift register
////////////////////////////////////////
`timescale 1ns/1ns

module joy_frame_reader
  import board_pkg::*;
(
  input  logic      ena_x,
  input  logic      pll_lckd,
  input  logic      joy_data,
  output logic      joy_load,
  output joy_word_t joy1,
  output joy_word_t joy2
);

  slot_t     slot_q;
  joy_bit_t  bit_idx;
  logic      cap_a;
  logic      cap_b;
  joy_word_t shadow_a;
  joy_word_t shadow_b;
  joy_word_t shadow_a_nxt;
  joy_word_t shadow_b_nxt;

  ////////////////////////////////////////
  // Slot counter and load
  ////////////////////////////////////////

  // Runs 0 to 25 and wraps
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      slot_q <= '0;
    end else if (slot_q == SLOT_LAST) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_q + slot_t'(1);
    end
  end

  // Register loads its parallel inputs in slot 0
  assign joy_load = (slot_q != '0);

  ////////////////////////////////////////
  // Slot table
  ////////////////////////////////////////

  // Stick 1 in slots 2-9 and 22-25
  assign cap_a = ((slot_q >= SLOT_FIRST_BIT) && (slot_q <= 5'd9)) || (slot_q >= 5'd22);
  // Stick 2 in slots 10-21
  assign cap_b = (slot_q >= 5'd10) && (slot_q <= 5'd21);

  // Both sticks share the same order per group
  always_comb begin
    case (slot_q)
      5'd2, 5'd10:  bit_idx = 4'd8;
      5'd3, 5'd11:  bit_idx = 4'd6;
      5'd4, 5'd12:  bit_idx = 4'd5;
      5'd5, 5'd13:  bit_idx = 4'd4;
      5'd6, 5'd14:  bit_idx = 4'd3;
      5'd7, 5'd15:  bit_idx = 4'd2;
      5'd8, 5'd16:  bit_idx = 4'd1;
      5'd9, 5'd17:  bit_idx = 4'd0;
      5'd18, 5'd22: bit_idx = 4'd10;
      5'd19, 5'd23: bit_idx = 4'd11;
      5'd20, 5'd24: bit_idx = 4'd9;
      5'd21, 5'd25: bit_idx = 4'd7;
      default:      bit_idx = 4'd0;
    endcase
  end

  // Shadow words with this slot's bit merged in
  always_comb begin
    shadow_a_nxt = shadow_a;
    shadow_b_nxt = shadow_b;
    if (cap_a) begin
      shadow_a_nxt[bit_idx] = joy_data;
    end
    if (cap_b) begin
      shadow_b_nxt[bit_idx] = joy_data;
    end
  end

  always_ff @(posedge ena_x) begin
    shadow_a <= shadow_a_nxt;
    shadow_b <= shadow_b_nxt;
  end

  ////////////////////////////////////////
  // Publish
  ////////////////////////////////////////

  // Last slot's bit goes straight through, both words at once
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy1 <= JOY_IDLE;
      joy2 <= JOY_IDLE;
    end else if (slot_q == SLOT_LAST) begin
      joy1 <= shadow_a_nxt;
      joy2 <= shadow_b_nxt;
    end
  end

endmodule

// ==== key_decoder.sv ====
////////////////////////////////////////
// Key decoder
// Turns scan codes into held flags for the
// board control keys
////////////////////////////////////////
`timescale 1ns/1ns

module key_decoder
  import board_pkg::*;
(
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  scan_code_t code,
  input  logic       code_valid,
  output key_ctrl_t  keys
);

  // Prefix tracking
  typedef enum logic [1:0] {
    st_idle,
    st_extended,
    st_release
  } key_state_t;

  key_state_t state_q;
  logic       key_make;
  logic       lctrl_q;
  logic       bksp_q;
  logic       f12_q;
  logic       scan_q;

  // Anything not preceded by F0 is a make
  assign key_make = (state_q != st_release);

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state_q <= st_idle;
      lctrl_q <= 1'b0;
      bksp_q  <= 1'b0;
      f12_q   <= 1'b0;
      scan_q  <= 1'b0;
    end else if (code_valid) begin
      if (code == SC_EXT) begin
        state_q <= st_extended;
      end else if (code == SC_BREAK) begin
        // E0 survives a following F0
        if (state_q == st_idle) begin
          state_q <= st_release;
        end
      end else begin
        // Plain code closes the sequence
        if (state_q != st_extended) begin
          case (code)
            SC_LCTRL: lctrl_q <= key_make;
            SC_BKSP:  bksp_q  <= key_make;
            SC_F12:   f12_q   <= key_make;
            SC_SCRLK: begin
              // Toggle on make only
              if (key_make) begin
                scan_q <= ~scan_q;
              end
            end
            default: ;
          endcase
        end
        state_q <= st_idle;
      end
    end
  end

  ////////////////////////////////////////
  // Control outputs
  ////////////////////////////////////////

  // Master reset needs both keys down together
  assign keys = '{
    reset_key:    f12_q,
    master_reset: lctrl_q & bksp_q,
    scan_mode:    scan_q
  };

endmodule

// ==== ps2_receiver.sv ====
////////////////////////////////////////
// PS/2 receiver
// Assembles 11-bit device frames into
// scan codes with a one-cycle strobe
////////////////////////////////////////
`timescale 1ns/1ns

module ps2_receiver
  import board_pkg::*;
(
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output scan_code_t code,
  output logic       code_valid
);

  // Index of the stop bit
  localparam logic [3:0] BIT_STOP = 4'd10;

  logic [1:0]  clk_sync;
  logic [1:0]  dat_sync;
  logic        clk_prev;
  logic        fall;
  logic [3:0]  bit_cnt;
  logic [9:0]  frame_q;
  logic [10:0] frame_nxt;
  logic        frame_ok;

  ////////////////////////////////////////
  // Synchronizer and edge detect
  ////////////////////////////////////////

  // Lines idle high
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_data};
      clk_prev <= clk_sync[1];
    end
  end

  // Device changes data on the rising edge
  assign fall = clk_prev & ~clk_sync[1];

  ////////////////////////////////////////
  // Frame assembly
  ////////////////////////////////////////

  // LSB first, so the start bit ends up in bit 0
  assign frame_nxt = {dat_sync[1], frame_q};

  // Start low, stop high, odd parity over data and parity
  assign frame_ok = ~frame_nxt[0] & frame_nxt[10] & (^frame_nxt[9:1]);

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt    <= '0;
      code_valid <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      if (fall) begin
        if ((bit_cnt == '0) && dat_sync[1]) begin
          // Not a start bit, wait for one
          bit_cnt <= '0;
        end else if (bit_cnt == BIT_STOP) begin
          bit_cnt    <= '0;
          code_valid <= frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge ena_x) begin
    if (fall) begin
      frame_q <= frame_nxt[10:1];
    end
    // Byte only means something with code_valid
    if (fall && (bit_cnt == BIT_STOP)) begin
      code <= frame_nxt[8:1];
    end
  end

endmodule

// ==== src.f ====
board_pkg.sv
joy_frame_reader.sv
ps2_receiver.sv
key_decoder.sv
board_ctrl.sv
board_input_top.sv
board_input_properties.sv
tb_board_input.sv

// ==== tb_board_input.sv ====
////////////////////////////////////////
// Board input testbench
// Joystick and PS/2 device models with
// reference checks of the front end
////////////////////////////////////////
`timescale 1ns/1ns

module tb_board_input
  import board_pkg::*;
;

  localparam int LIMIT = 30 * 26 + 20 * 100 + 200;

  logic ena_x, pll_lckd, joy_clk, joy_load, joy_data;
  logic ps2_clk, ps2_data, btn, scandbl;
  logic core_reset, reboot_req, led;
  core_in_t core_in, exp_core;
  joy_word_t cur_a, cur_b, done_a, done_b, next_a, next_b;
  logic next_btn, joy_check, r_ext, r_brk, r_lctrl, r_bksp, r_f12, r_scan;
  logic [31:0] lfsr;
  int errors, cycles, tslot, frame_cnt, frames_checked, valid_cnt, reboot_cnt, n, r0;

  board_input_top #(.HOLD_CYCLES(32)) i_dut (.*);

  initial begin
    ena_x = 1'b0;
    forever #20 ena_x = ~ena_x;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic core_in_t ref_core(input joy_word_t a, input joy_word_t b, input logic bt);
    core_in_t c;
    c.stick_a  = a[5:0];
    c.stick_b  = b[5:0];
    c.player_n = {b[8], a[8]};
    c.coin_n   = {b[9], a[9] & bt};
    return c;
  endfunction

  // Key model, same prefix rules as a set 2 keyboard
  function automatic void ref_key(input logic [7:0] c);
    if (c == 8'he0) begin
      r_ext = 1'b1;
    end else if (c == 8'hf0) begin
      r_brk = 1'b1;
    end else begin
      if (!r_ext) begin
        if (c == 8'h14) r_lctrl = !r_brk;
        if (c == 8'h66) r_bksp = !r_brk;
        if (c == 8'h07) r_f12 = !r_brk;
        if (c == 8'h7e && !r_brk) r_scan = !r_scan;
      end
      r_ext = 1'b0;
      r_brk = 1'b0;
    end
  endfunction

  // Bit presented in each slot of the frame
  function automatic logic slot_bit(input int s);
    case (s)
      2:  return cur_a[8];
      3:  return cur_a[6];
      4:  return cur_a[5];
      5:  return cur_a[4];
      6:  return cur_a[3];
      7:  return cur_a[2];
      8:  return cur_a[1];
      9:  return cur_a[0];
      10: return cur_b[8];
      11: return cur_b[6];
      12: return cur_b[5];
      13: return cur_b[4];
      14: return cur_b[3];
      15: return cur_b[2];
      16: return cur_b[1];
      17: return cur_b[0];
      18: return cur_b[10];
      19: return cur_b[11];
      20: return cur_b[9];
      21: return cur_b[7];
      22: return cur_a[10];
      23: return cur_a[11];
      24: return cur_a[9];
      25: return cur_a[7];
      default: return 1'b1;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic cyc(input int k);
    repeat (k) begin
      @(posedge ena_x);
      #2;
    end
  endtask

  task automatic wait_frames(input int k);
    int target;
    target = frame_cnt + k;
    while (frame_cnt < target) @(negedge ena_x);
  endtask

  function automatic joy_word_t rand_word();
    joy_word_t w;
    for (int i = 0; i < 12; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  // One PS/2 frame, data set while the clock is high
  task automatic send_ps2(input logic [7:0] c, input logic bad);
    logic [10:0] fr;
    fr = {1'b1, (~^c) ^ bad, c, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_data = fr[i];
      cyc(4);
      ps2_clk = 1'b0;
      cyc(4);
      ps2_clk = 1'b1;
    end
  endtask

  // Good frame, then keys one cycle and outputs one more
  task automatic send_key(input logic [7:0] c);
    int v0, k;
    v0 = valid_cnt;
    k = 0;
    send_ps2(c, 1'b0);
    ref_key(c);
    while (valid_cnt == v0 && k < 20) begin
      cyc(1);
      k++;
    end
    if (valid_cnt == v0) begin
      errors++;
      $display("No scan code strobe after keyboard frame %h", c);
    end
    cyc(1);
    check("led", led, r_scan ^ scandbl);
    check("core_reset", core_reset, r_f12);
  endtask

  ////////////////////////////////////////
  // Joystick shift register model
  ////////////////////////////////////////
  always @(posedge ena_x) begin
    #2;
    if (!joy_load) begin
      tslot = 0;
      done_a = cur_a;
      done_b = cur_b;
      cur_a = next_a;
      cur_b = next_b;
      btn = next_btn;
      exp_core = ref_core(done_a, done_b, next_btn);
      frame_cnt++;
    end else begin
      tslot++;
    end
    joy_data = slot_bit(tslot);
  end

  // Shift register clock follows the system clock
  always @(ena_x) begin
    #1;
    check("joy_clk", joy_clk, ena_x);
  end

  // Compare one cycle after each published frame
  always @(negedge ena_x) begin
    if (joy_check && tslot == 1) begin
      check("core_in", core_in, exp_core);
      frames_checked++;
    end
    if (i_dut.code_valid) valid_cnt++;
    if (reboot_req) reboot_cnt++;
  end

  always @(posedge ena_x) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    pll_lckd = 1'b0;
    joy_data = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    btn = 1'b1;
    scandbl = 1'b0;
    next_a = JOY_IDLE;
    next_b = JOY_IDLE;
    cur_a = JOY_IDLE;
    cur_b = JOY_IDLE;
    next_btn = 1'b1;
    joy_check = 1'b0;
    {r_ext, r_brk, r_lctrl, r_bksp, r_f12, r_scan} = '0;
    lfsr = 32'hcfb6e740;
    repeat (8) @(posedge ena_x);
    #2;
    pll_lckd = 1'b1;
    check("joy_load", joy_load, 1'b0);
    check("reboot_req", reboot_req, 1'b0);
    check("led", led, scandbl);
    check("core_in", core_in, ref_core(JOY_IDLE, JOY_IDLE, btn));
    // Power-on hold
    n = 0;
    while (core_reset && n < 100) begin
      cyc(1);
      n++;
    end
    check("hold_cycles", n, 32);
    joy_check = 1'b1;
    for (int i = 0; i < 20; i++) begin
      next_a = rand_word();
      next_b = rand_word();
      next_btn = i[0];
      wait_frames(1);
    end
    next_a = JOY_IDLE;
    next_b = JOY_IDLE;
    next_btn = 1'b1;
    wait_frames(3);
    // Keyboard
    send_key(8'h7e);
    send_key(8'hf0);
    send_key(8'h7e);
    send_key(8'h07);
    send_key(8'hf0);
    send_key(8'h07);
    n = valid_cnt;
    send_ps2(8'h7e, 1'b1);
    cyc(30);
    check("bad_frame_strobes", valid_cnt - n, 0);
    check("led", led, r_scan ^ scandbl);
    // Scan doubler switch flips the LED
    scandbl = 1'b1;
    cyc(2);
    check("led", led, r_scan ^ scandbl);
    // Ctrl and backspace
    r0 = reboot_cnt;
    send_key(8'h14);
    send_key(8'h66);
    cyc(5);
    send_key(8'hf0);
    send_key(8'h14);
    send_key(8'hf0);
    send_key(8'h66);
    check("reboot_pulses_keys", reboot_cnt - r0, 1);
    // Stick 2 reset button
    r0 = reboot_cnt;
    next_b = JOY_IDLE & ~12'h800;
    wait_frames(1);
    next_b = JOY_IDLE;
    wait_frames(3);
    check("reboot_pulses_joy", reboot_cnt - r0, 1);
    // Stick 1 reset button, one frame long
    next_a = JOY_IDLE & ~12'h800;
    wait_frames(1);
    next_a = JOY_IDLE;
    n = 0;
    repeat (3 * 26) begin
      cyc(1);
      if (core_reset) n++;
    end
    check("core_reset_cycles", n, 26);
    check("frames_checked", frames_checked >= 20, 1'b1);
    $display("Errors: %0d, frames checked: %0d", errors, frames_checked);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
